// ==== Bender.yml ====
package:
  name: amo_unit

dependencies: {}

sources:
  # package first, then leaf modules, then the top level
  - verilog/amo_pkg.sv
  - verilog/amo_alu.sv
  - verilog/amo_rmw.sv
  - verilog/amo_mem.sv
  - verilog/amo_top.sv

  # testbench, top module amo_tb
  - target: test
    files:
      - verification/amo_tb.sv

// ==== compile.f ====
verilog/amo_pkg.sv
verilog/amo_alu.sv
verilog/amo_rmw.sv
verilog/amo_mem.sv
verilog/amo_top.sv
verification/amo_tb.sv

// ==== verification/amo_tb.sv ====
/* assumes reset clears the memory, so the shadow model starts at zero.
   requests go out on the falling edge and are held while req_rdy is low */

`timescale 1ns/1ps

module amo_tb
  import amo_pkg::*;
();

  localparam int unsigned ADR_W = 6;
  localparam int unsigned DAT_W = 32;
  localparam int unsigned DEPTH = 2 ** ADR_W;
  // requests per test, the watchdog is sized from these
  localparam int N_PLAIN  = 20;
  localparam int N_DIRECT = 108;
  localparam int N_UNDEF  = 12;
  localparam int N_RAND   = 300;
  localparam int N_READY  = 12;
  localparam int N_TOTAL  = N_PLAIN + N_DIRECT + N_UNDEF + N_RAND + N_READY;

  logic             clk;
  logic             rst_n;
  logic             req_vld;
  logic             req_rdy;
  req_ctl_t         req_ctl;
  logic [ADR_W-1:0] req_adr;
  logic [DAT_W-1:0] req_wdt;
  logic             rsp_vld;
  logic [DAT_W-1:0] rsp_rdt;
  logic             rsp_err;

  // shadow of the memory contents
  logic [DAT_W-1:0] shadow [DEPTH];
  // expected responses in acceptance order
  logic [DAT_W-1:0] exp_rdt_q [$];
  logic             exp_err_q [$];
  logic [DAT_W-1:0] exp_rdt;
  logic             exp_err;
  // cycle expectations, sampled on the rising edge
  logic             rsp_due;
  logic             gap_due;
  // bookkeeping
  logic [31:0]      seed;
  string            test_name;
  int               errors;
  int               test_err0;
  int               tests_run;
  int               tests_failed;
  int               n_req;
  int               n_rsp;
  // directed tables and random stream state
  amo_op_t          ops [9];
  logic [DAT_W-1:0] old_vals [4];
  logic [DAT_W-1:0] opd_vals [4];
  logic [31:0]      rnd;
  logic [31:0]      rnd_hi;
  logic [DAT_W-1:0] wd;
  logic [ADR_W-1:0] last_adr;
  logic             follow;

  amo_top amo_top_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .req_vld (req_vld),
    .req_rdy (req_rdy),
    .req_ctl (req_ctl),
    .req_adr (req_adr),
    .req_wdt (req_wdt),
    .rsp_vld (rsp_vld),
    .rsp_rdt (rsp_rdt),
    .rsp_err (rsp_err)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  //////////////////////////////////////////////////////////////////////
  // reference model
  //////////////////////////////////////////////////////////////////////

  // plain LCG, constants from Numerical Recipes
  function automatic logic [31:0] next_rand();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  function automatic logic op_defined(input amo_op_t op);
    case (op)
      AMOADD, AMOSWAP, AMOXOR, AMOOR, AMOAND,
      AMOMIN, AMOMAX, AMOMINU, AMOMAXU: return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

  // expected response and new word for one request against the old word
  function automatic void ref_op(input req_ctl_t ctl, input logic [DAT_W-1:0] opd,
                                 input logic [DAT_W-1:0] old,
                                 output logic [DAT_W-1:0] rdt, output logic err,
                                 output logic wr, output logic [DAT_W-1:0] new_w);
    rdt   = '0;
    err   = 1'b0;
    wr    = 1'b0;
    new_w = old;
    if (ctl.amo) begin
      // atomics hand back the old word
      rdt = old;
      wr  = 1'b1;
      case (ctl.op)
        AMOADD:  new_w = old + opd;
        AMOSWAP: new_w = opd;
        AMOXOR:  new_w = old ^ opd;
        AMOOR:   new_w = old | opd;
        AMOAND:  new_w = old & opd;
        AMOMIN:  new_w = ($signed(opd) < $signed(old)) ? opd : old;
        AMOMAX:  new_w = ($signed(opd) > $signed(old)) ? opd : old;
        AMOMINU: new_w = (opd < old) ? opd : old;
        AMOMAXU: new_w = (opd > old) ? opd : old;
        default: begin
          // error, no data and no write
          rdt = '0;
          err = 1'b1;
          wr  = 1'b0;
        end
      endcase
    end else if (ctl.wen) begin
      wr    = 1'b1;
      new_w = opd;
    end else if (ctl.ren) begin
      rdt = old;
    end
  endfunction

  //////////////////////////////////////////////////////////////////////
  // stimulus tasks
  //////////////////////////////////////////////////////////////////////

  // called on a falling edge, returns on the falling edge after the transfer
  task automatic send_req(input req_ctl_t ctl, input logic [ADR_W-1:0] adr,
                          input logic [DAT_W-1:0] dat);
    logic [DAT_W-1:0] rdt;
    logic             err;
    logic             wr;
    logic [DAT_W-1:0] new_w;
    req_vld = 1'b1;
    req_ctl = ctl;
    req_adr = adr;
    req_wdt = dat;
    // req_rdy is settled by now, it only moves on the rising edge
    while (!req_rdy) begin
      @(negedge clk);
    end
    ref_op(ctl, dat, shadow[adr], rdt, err, wr, new_w);
    if (wr) begin
      shadow[adr] = new_w;
    end
    exp_rdt_q.push_back(rdt);
    exp_err_q.push_back(err);
    n_req++;
    @(negedge clk);
  endtask

  task automatic wr_word(input logic [ADR_W-1:0] adr, input logic [DAT_W-1:0] dat);
    req_ctl_t ctl;
    ctl     = '0;
    ctl.wen = 1'b1;
    send_req(ctl, adr, dat);
  endtask

  task automatic rd_word(input logic [ADR_W-1:0] adr);
    req_ctl_t ctl;
    ctl     = '0;
    ctl.ren = 1'b1;
    send_req(ctl, adr, '0);
  endtask

  task automatic amo_word(input amo_op_t op, input logic [ADR_W-1:0] adr,
                          input logic [DAT_W-1:0] dat);
    req_ctl_t ctl;
    ctl     = '0;
    ctl.amo = 1'b1;
    ctl.op  = op;
    send_req(ctl, adr, dat);
  endtask

  task automatic start_test(input string name);
    test_name = name;
    test_err0 = errors;
  endtask

  // wait out the responses, then report the test
  task automatic end_test();
    req_vld = 1'b0;
    while (exp_rdt_q.size() != 0) begin
      @(negedge clk);
    end
    @(negedge clk);
    tests_run++;
    if (errors != test_err0) begin
      tests_failed++;
    end
    $display("test %-10s done, %0d errors", test_name, errors - test_err0);
  endtask

  //////////////////////////////////////////////////////////////////////
  // comparison
  //////////////////////////////////////////////////////////////////////

  // response due one cycle after a transfer, gap after a defined atomic
  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rsp_due <= 1'b0;
      gap_due <= 1'b0;
    end else begin
      rsp_due <= req_vld && req_rdy;
      gap_due <= req_vld && req_rdy && req_ctl.amo && op_defined(req_ctl.op);
    end
  end

  // outputs are stable at the falling edge
  always @(negedge clk) begin
    if (rst_n) begin
      assert (rsp_vld == rsp_due) else begin
        errors++;
        $display("FAIL %s: expected rsp_vld %0b, actual rsp_vld %0b",
                 test_name, rsp_due, rsp_vld);
      end
      assert (req_rdy == !gap_due) else begin
        errors++;
        $display("FAIL %s: expected req_rdy %0b, actual req_rdy %0b",
                 test_name, !gap_due, req_rdy);
      end
      if (rsp_vld) begin
        assert (exp_rdt_q.size() != 0) else begin
          errors++;
          $display("response with no request outstanding in test %s", test_name);
        end
        if (exp_rdt_q.size() != 0) begin
          exp_rdt = exp_rdt_q.pop_front();
          exp_err = exp_err_q.pop_front();
          n_rsp++;
          assert (rsp_rdt === exp_rdt && rsp_err === exp_err) else begin
            errors++;
            $display("FAIL %s: expected rdt %h err %b, actual rdt %h err %b",
                     test_name, exp_rdt, exp_err, rsp_rdt, rsp_err);
          end
        end
      end
    end
  end

  // bound from the request count
  initial begin
    repeat (N_TOTAL * 4 + 100) @(posedge clk);
    $display("watchdog expired, %0d of %0d requests sent, %0d responses missing",
             n_req, N_TOTAL, exp_rdt_q.size());
    $display("*** FAILED ***");
    $finish;
  end

  //////////////////////////////////////////////////////////////////////
  // tests
  //////////////////////////////////////////////////////////////////////

  initial begin
    seed         = 32'd14;
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    n_req        = 0;
    n_rsp        = 0;
    test_name    = "reset";
    follow       = 1'b0;
    last_adr     = '0;
    rst_n        = 1'b0;
    req_vld      = 1'b0;
    req_ctl      = '0;
    req_adr      = '0;
    req_wdt      = '0;
    for (int i = 0; i < DEPTH; i++) begin
      shadow[i] = '0;
    end
    ops = '{AMOADD, AMOSWAP, AMOXOR, AMOOR, AMOAND,
            AMOMIN, AMOMAX, AMOMINU, AMOMAXU};
    // -1 vs 2, max pos vs min neg, equal min neg, plain bit pattern
    old_vals = '{32'hFFFF_FFFF, 32'h7FFF_FFFF, 32'h8000_0000, 32'h1234_5678};
    opd_vals = '{32'h0000_0002, 32'h8000_0000, 32'h8000_0000, 32'h0F0F_F0F0};
    repeat (8) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);

    // writes to even words, read back, odd words untouched
    start_test("plain");
    for (int i = 0; i < 8; i++) begin
      wr_word(2 * i, next_rand());
    end
    for (int i = 0; i < 8; i++) begin
      rd_word(2 * i);
    end
    for (int i = 0; i < 4; i++) begin
      rd_word(2 * i + 1);
    end
    end_test();

    // every code on every pair, read right behind the atomic
    start_test("directed");
    for (int o = 0; o < 9; o++) begin
      for (int p = 0; p < 4; p++) begin
        wr_word(4 * o + p, old_vals[p]);
        amo_word(ops[o], 4 * o + p, opd_vals[p]);
        rd_word(4 * o + p);
      end
    end
    end_test();

    start_test("undefined");
    for (int i = 0; i < 4; i++) begin
      wr_word(40 + i, 32'hA5A5_0000 + i);
    end
    amo_word(amo_op_t'(5'b00010), 40, 32'h1111_1111);
    amo_word(amo_op_t'(5'b00011), 41, 32'h2222_2222);
    amo_word(amo_op_t'(5'b10001), 42, 32'h3333_3333);
    amo_word(amo_op_t'(5'b11111), 43, 32'h4444_4444);
    for (int i = 0; i < 4; i++) begin
      rd_word(40 + i);
    end
    end_test();

    // 16 words only, so addresses collide often
    start_test("random");
    for (int i = 0; i < N_RAND; i++) begin
      rnd    = next_rand();
      rnd_hi = next_rand();
      case (rnd[7:4])
        4'd0:    wd = 32'h8000_0000;
        4'd1:    wd = 32'hFFFF_FFFF;
        4'd2:    wd = 32'h7FFF_FFFF;
        default: wd = {rnd_hi[31:16], rnd[31:16]};
      endcase
      if (follow) begin
        // read straight behind the atomic
        rd_word(last_adr);
        follow = 1'b0;
      end else if (rnd[29:28] == 2'd0) begin
        rd_word(rnd_hi[11:8]);
      end else if (rnd[29:28] == 2'd1) begin
        wr_word(rnd_hi[11:8], wd);
      end else begin
        last_adr = rnd_hi[11:8];
        follow   = rnd[12];
        if (rnd[15:13] == 3'd0) begin
          amo_word(amo_op_t'(rnd_hi[4:0]), last_adr, wd);
        end else begin
          amo_word(ops[rnd_hi[27:24] % 9], last_adr, wd);
        end
      end
    end
    end_test();

    // atomics back to back, gaps checked every cycle
    start_test("ready");
    amo_word(AMOADD, 50, 32'd1);
    amo_word(AMOADD, 50, 32'd2);
    amo_word(AMOADD, 50, 32'd3);
    amo_word(AMOMAXU, 50, 32'd4);
    wr_word(51, 32'hDEAD_0001);
    amo_word(AMOSWAP, 51, 32'h0000_BEEF);
    rd_word(51);
    rd_word(50);
    amo_word(AMOMIN, 51, 32'hFFFF_FFF0);
    amo_word(amo_op_t'(5'b00111), 50, 32'd9);
    rd_word(50);
    wr_word(52, 32'd7);
    end_test();

    $display("%0d tests, %0d failed, %0d requests, %0d responses, %0d errors",
             tests_run, tests_failed, n_req, n_rsp, errors);
    if (errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule : amo_tb

// ==== verilog/amo_alu.sv ====
/* purely combinational; new_dat is meaningless while op_ok is low.
   one shared adder does ADD and the MIN/MAX compares */

`timescale 1ns/1ps

module amo_alu
  import amo_pkg::*;
#(
  parameter int unsigned DAT_W = 32
) (
  // function code
  input  amo_op_t          op,
  // operand from the requester
  input  logic [DAT_W-1:0] wdt,
  // old memory word
  input  logic [DAT_W-1:0] rdt,
  // word to be written back
  output logic [DAT_W-1:0] new_dat,
  // low for undefined codes
  output logic             op_ok
);

  //////////////////////////////////////////////////////////////////////
  // shared adder
  //////////////////////////////////////////////////////////////////////

  // subtract for compares, add for AMOADD
  logic           cmp;
  // unsigned compare
  logic           uns;
  // operands extended by one bit
  logic [DAT_W:0] opa;
  logic [DAT_W:0] opb;
  // adder result, top bit is the compare sign
  logic [DAT_W:0] sum;
  // wdt below rdt
  logic           lt;

  always_comb begin
    cmp = op inside {AMOMIN, AMOMAX, AMOMINU, AMOMAXU};
    uns = op inside {AMOMINU, AMOMAXU};
    // sign extension for signed compare, zero extension for unsigned
    // the extra bit keeps wdt - rdt from overflowing
    opa = {~uns & wdt[DAT_W-1], wdt};
    opb = {~uns & rdt[DAT_W-1], rdt};
    // two's complement subtract by invert and carry in
    sum = opa + (cmp ? ~opb : opb) + {{DAT_W{1'b0}}, cmp};
    // negative difference
    lt  = sum[DAT_W];
  end

  //////////////////////////////////////////////////////////////////////
  // result select
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    op_ok = 1'b1;
    case (op)
      // pass operand through
      AMOSWAP: begin
        new_dat = wdt;
      end
      // wraps silently, carry out dropped
      AMOADD: begin
        new_dat = sum[DAT_W-1:0];
      end
      AMOXOR: begin
        new_dat = wdt ^ rdt;
      end
      AMOAND: begin
        new_dat = wdt & rdt;
      end
      AMOOR: begin
        new_dat = wdt | rdt;
      end
      // smaller of the two
      AMOMIN, AMOMINU: begin
        new_dat = lt ? wdt : rdt;
      end
      // larger of the two, equal keeps operand
      AMOMAX, AMOMAXU: begin
        new_dat = lt ? rdt : wdt;
      end
      // undefined code, keep old word
      default: begin
        new_dat = rdt;
        op_ok   = 1'b0;
      end
    endcase
  end

endmodule : amo_alu

// ==== verilog/amo_mem.sv ====
/* single port; ren and wen must not be set in the same cycle.
   reset clears every word, so reset takes 2^ADR_W flops worth of fanout */

`timescale 1ns/1ps

module amo_mem
  import amo_pkg::*;
#(
  parameter int unsigned ADR_W = 6,
  parameter int unsigned DAT_W = 32
) (
  input  logic             clk,
  input  logic             rst_n,
  // command from the rmw unit
  input  mem_cmd_t         mem_cmd,
  input  logic [ADR_W-1:0] mem_adr,
  input  logic [DAT_W-1:0] mem_wdt,
  // valid the cycle after ren
  output logic [DAT_W-1:0] mem_rdt
);

  localparam int unsigned DEPTH = 2 ** ADR_W;

  // word array
  logic [DAT_W-1:0] mem [DEPTH];

  //////////////////////////////////////////////////////////////////////
  // write
  //////////////////////////////////////////////////////////////////////

  // cleared to zero on reset
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < DEPTH; i++) begin
        mem[i] <= '0;
      end
    end else if (mem_cmd.wen) begin
      mem[mem_adr] <= mem_wdt;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // read
  //////////////////////////////////////////////////////////////////////

  // registered output, holds between reads
  always_ff @(posedge clk) begin
    if (mem_cmd.ren) begin
      mem_rdt <= mem[mem_adr];
    end
  end

  // rmw unit never mixes a read and a write on the port
  a_one_cmd: assert property (@(posedge clk) disable iff (!rst_n)
    !(mem_cmd.ren && mem_cmd.wen));

endmodule : amo_mem

// ==== verilog/amo_pkg.sv ====
/* function codes follow the RISC-V funct5 encoding; any other code is undefined.
   when amo is set in a request, its ren and wen are ignored */

package amo_pkg;

  //////////////////////////////////////////////////////////////////////
  // atomic function codes
  //////////////////////////////////////////////////////////////////////

  // funct5 field of the RISC-V AMO instructions
  // the enum is 5 bits wide, so undefined codes can still be carried
  typedef enum logic [4:0] {
    AMOADD  = 5'b00000,
    AMOSWAP = 5'b00001,
    AMOXOR  = 5'b00100,
    AMOOR   = 5'b01000,
    AMOAND  = 5'b01100,
    // signed compare
    AMOMIN  = 5'b10000,
    AMOMAX  = 5'b10100,
    // unsigned compare
    AMOMINU = 5'b11000,
    AMOMAXU = 5'b11100
  } amo_op_t;

  //////////////////////////////////////////////////////////////////////
  // requester side control
  //////////////////////////////////////////////////////////////////////

  // request control, 8 bits
  // when amo is set, ren and wen are ignored
  // a plain request with both ren and wen set is treated as a write
  typedef struct packed {
    // read enable
    logic    ren;
    // write enable
    logic    wen;
    // atomic read-modify-write
    logic    amo;
    // atomic function, only looked at with amo
    amo_op_t op;
  } req_ctl_t;

  //////////////////////////////////////////////////////////////////////
  // memory side control
  //////////////////////////////////////////////////////////////////////

  // memory command, 2 bits
  // read data follows one cycle after ren
  // ren and wen are never set together
  typedef struct packed {
    logic ren;
    logic wen;
  } mem_cmd_t;

endpackage : amo_pkg

// ==== verilog/amo_rmw.sv ====
/* the requester must always take a response; there is no response ready.
   an atomic holds req_rdy low for one cycle while its write goes out */

`timescale 1ns/1ps

module amo_rmw
  import amo_pkg::*;
#(
  parameter int unsigned ADR_W = 6,
  parameter int unsigned DAT_W = 32
) (
  input  logic             clk,
  input  logic             rst_n,
  // request channel
  input  logic             req_vld,
  output logic             req_rdy,
  input  req_ctl_t         req_ctl,
  input  logic [ADR_W-1:0] req_adr,
  input  logic [DAT_W-1:0] req_wdt,
  // response strobe
  output logic             rsp_vld,
  output logic [DAT_W-1:0] rsp_rdt,
  output logic             rsp_err,
  // memory port
  output mem_cmd_t         mem_cmd,
  output logic [ADR_W-1:0] mem_adr,
  output logic [DAT_W-1:0] mem_wdt,
  input  logic [DAT_W-1:0] mem_rdt
);

  // request transfer
  logic             req_trn;
  // stage holding the accepted request
  logic             stg_vld;
  req_ctl_t         stg_ctl;
  logic [ADR_W-1:0] stg_adr;
  logic [DAT_W-1:0] stg_wdt;
  // alu result and code check
  logic [DAT_W-1:0] alu_dat;
  logic             alu_ok;
  // write cycle of a valid atomic
  logic             busy;
  // response carries memory data
  logic             stg_rd;

  //////////////////////////////////////////////////////////////////////
  // handshake and request stage
  //////////////////////////////////////////////////////////////////////

  assign req_rdy = ~busy;
  assign req_trn = req_vld & req_rdy;

  // control state
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      stg_vld <= 1'b0;
      stg_ctl <= '0;
    end else begin
      stg_vld <= req_trn;
      if (req_trn) begin
        stg_ctl <= req_ctl;
      end
    end
  end

  // payload, only used while stg_vld
  always_ff @(posedge clk) begin
    if (req_trn) begin
      stg_adr <= req_adr;
      stg_wdt <= req_wdt;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // modify
  //////////////////////////////////////////////////////////////////////

  // old word arrives straight from memory
  amo_alu #(
    .DAT_W (DAT_W)
  ) amo_alu_i (
    .op      (stg_ctl.op),
    .wdt     (stg_wdt),
    .rdt     (mem_rdt),
    .new_dat (alu_dat),
    .op_ok   (alu_ok)
  );

  // undefined codes never get the write cycle
  assign busy = stg_vld & stg_ctl.amo & alu_ok;

  //////////////////////////////////////////////////////////////////////
  // memory command
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    if (busy) begin
      // write back of the atomic
      mem_cmd.ren = 1'b0;
      mem_cmd.wen = 1'b1;
      mem_adr     = stg_adr;
      mem_wdt     = alu_dat;
    end else begin
      // atomics always read first, plain write wins over plain read
      mem_cmd.ren = req_trn & (req_ctl.amo | (req_ctl.ren & ~req_ctl.wen));
      mem_cmd.wen = req_trn & ~req_ctl.amo & req_ctl.wen;
      mem_adr     = req_adr;
      mem_wdt     = req_wdt;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // response
  //////////////////////////////////////////////////////////////////////

  // reads and valid atomics return the memory word, others zero
  assign stg_rd  = stg_ctl.amo ? alu_ok : (stg_ctl.ren & ~stg_ctl.wen);
  assign rsp_vld = stg_vld;
  assign rsp_rdt = stg_rd ? mem_rdt : '0;
  assign rsp_err = stg_vld & stg_ctl.amo & ~alu_ok;

  //////////////////////////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////////////////////////

  // memory data in a response comes from a read issued one cycle before
  a_rsp_read: assert property (@(posedge clk) disable iff (!rst_n)
    (rsp_vld && stg_rd) |-> $past(mem_cmd.ren));

  // undefined atomic, next cycle only a new plain write may hit memory
  a_no_bad_write: assert property (@(posedge clk) disable iff (!rst_n)
    (req_vld && req_rdy && req_ctl.amo &&
     !(req_ctl.op inside {AMOADD, AMOSWAP, AMOXOR, AMOOR, AMOAND,
                          AMOMIN, AMOMAX, AMOMINU, AMOMAXU}))
    |=> (mem_cmd.wen == (req_vld && req_rdy && !req_ctl.amo && req_ctl.wen)));

endmodule : amo_rmw

// ==== verilog/amo_top.sv ====
/* requester must accept every response; widths are set here and passed down.
   memory is 2^ADR_W words of DAT_W bits, cleared by reset */

`timescale 1ns/1ps

module amo_top
  import amo_pkg::*;
#(
  parameter int unsigned ADR_W = 6,
  parameter int unsigned DAT_W = 32
) (
  input  logic             clk,
  input  logic             rst_n,
  // request channel
  input  logic             req_vld,
  output logic             req_rdy,
  input  req_ctl_t         req_ctl,
  input  logic [ADR_W-1:0] req_adr,
  input  logic [DAT_W-1:0] req_wdt,
  // response strobe
  output logic             rsp_vld,
  output logic [DAT_W-1:0] rsp_rdt,
  output logic             rsp_err
);

  // memory port between rmw and ram
  mem_cmd_t         mem_cmd;
  logic [ADR_W-1:0] mem_adr;
  logic [DAT_W-1:0] mem_wdt;
  logic [DAT_W-1:0] mem_rdt;

  // sequencer
  amo_rmw #(
    .ADR_W (ADR_W),
    .DAT_W (DAT_W)
  ) amo_rmw_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .req_vld (req_vld),
    .req_rdy (req_rdy),
    .req_ctl (req_ctl),
    .req_adr (req_adr),
    .req_wdt (req_wdt),
    .rsp_vld (rsp_vld),
    .rsp_rdt (rsp_rdt),
    .rsp_err (rsp_err),
    .mem_cmd (mem_cmd),
    .mem_adr (mem_adr),
    .mem_wdt (mem_wdt),
    .mem_rdt (mem_rdt)
  );

  // word memory, one cycle read latency
  amo_mem #(
    .ADR_W (ADR_W),
    .DAT_W (DAT_W)
  ) amo_mem_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .mem_cmd (mem_cmd),
    .mem_adr (mem_adr),
    .mem_wdt (mem_wdt),
    .mem_rdt (mem_rdt)
  );

endmodule : amo_top
